/* flist.f */
+incdir+rtl
rtl/decode_pkg.sv
rtl/stable_counter.sv
rtl/decoder.sv
rtl/decode_stage.sv
rtl/redirect_unit.sv
rtl/decode_frontend_top.sv
test/decode_frontend_chk.sv
test/decode_frontend_tb.sv

/* rtl/decode_frontend_top.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_frontend_top (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire                            in_valid,
  input  wire decode_pkg::fetch_bundle_t in_bundle,
  output logic                           out_valid,
  output decode_pkg::decoded_bundle_t    out_bundle,
  output decode_pkg::redirect_t          redirect
);

  import decode_pkg::*;

  cnt_t counter;
  logic kill;

  stable_counter i_stable_counter (
    .clk     (clk),
    .arst_n  (arst_n),
    .counter (counter)
  );

  decode_stage i_decode_stage (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_bundle  (in_bundle),
    .counter    (counter),
    .kill       (kill),
    .out_valid  (out_valid),
    .out_bundle (out_bundle)
  );

  redirect_unit i_redirect_unit (
    .out_valid  (out_valid),
    .out_bundle (out_bundle),
    .redirect   (redirect),
    .kill       (kill)
  );

endmodule

`default_nettype wire

/* rtl/decode_pkg.sv */
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

  typedef logic [`INST_W-1:0] word_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [`CNT_W-1:0] cnt_t;
  typedef logic [3:0] opcode_t;

  typedef enum logic [2:0] {OP_ALU, OP_MUL, OP_DIV, OP_MEM, OP_CSR, OP_TLB} optype_t;

  typedef enum logic [2:0] {BR_NOP, BR_COND, BR_IMM, BR_CALL, BR_INDIR, BR_RET} br_type_t;

  typedef enum logic [2:0] {EXCP_NONE, EXCP_SYS, EXCP_BRK, EXCP_INE, EXCP_ERTN} excp_t;

  // alu sub-opcodes
  localparam opcode_t ALU_ADD  = 4'd0;
  localparam opcode_t ALU_SUB  = 4'd1;
  localparam opcode_t ALU_SLT  = 4'd2;
  localparam opcode_t ALU_SLTU = 4'd3;
  localparam opcode_t ALU_AND  = 4'd4;
  localparam opcode_t ALU_OR   = 4'd5;
  localparam opcode_t ALU_NOR  = 4'd6;
  localparam opcode_t ALU_XOR  = 4'd7;
  localparam opcode_t ALU_SLL  = 4'd8;
  localparam opcode_t ALU_SRL  = 4'd9;
  localparam opcode_t ALU_SRA  = 4'd10;
  localparam opcode_t ALU_EQU  = 4'd11;
  // passes operand 2 straight through
  localparam opcode_t ALU_OUT2 = 4'd12;

  localparam opcode_t MUL_MUL   = 4'd0;
  localparam opcode_t MUL_MULH  = 4'd1;
  localparam opcode_t MUL_MULHU = 4'd2;

  localparam opcode_t DIV_DIV  = 4'd0;
  localparam opcode_t DIV_DIVU = 4'd1;
  localparam opcode_t DIV_MOD  = 4'd2;
  localparam opcode_t DIV_MODU = 4'd3;

  localparam opcode_t TLB_TLBSRCH = 4'd0;
  localparam opcode_t TLB_TLBRD   = 4'd1;
  localparam opcode_t TLB_TLBWR   = 4'd2;
  localparam opcode_t TLB_TLBFILL = 4'd3;
  localparam opcode_t TLB_INVTLB  = 4'd4;

  // memory opcode is {kind, size}
  localparam logic [1:0] MEM_LOAD_S = 2'd0;
  localparam logic [1:0] MEM_LOAD_U = 2'd1;
  localparam logic [1:0] MEM_STORE  = 2'd2;
  localparam logic [1:0] MEM_BYTE   = 2'd0;
  localparam logic [1:0] MEM_HALF   = 2'd1;
  localparam logic [1:0] MEM_WORD   = 2'd2;

  typedef struct packed {
    word_t pc;
    word_t inst;
    logic  pred_taken;
    word_t pred_target;
  } fetch_bundle_t;

  typedef struct packed {
    word_t     pc;
    optype_t   optype;
    opcode_t   opcode;
    reg_idx_t  r1;
    reg_idx_t  r2;
    reg_idx_t  dest;
    logic      src2_is_imm;
    word_t     imm;
    br_type_t  br_type;
    logic      br_condition;
    word_t     br_target;
    logic      br_taken;
    logic      br_mistaken;
    logic      have_excp;
    excp_t     excp_type;
    csr_addr_t csr_addr;
    logic      csr_wr;
  } decoded_bundle_t;

  typedef struct packed {
    logic  valid;
    word_t target;
  } redirect_t;

endpackage

`default_nettype wire

/* rtl/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// one word, used for instructions, pcs and immediates
`define INST_W 32

// stable counter width
`define CNT_W 64

// integer register index
`define REG_IDX_W 5

// csr number width
`define CSR_ADDR_W 14

// csr number read by rdcnt.id
`define CSR_TID_ADDR 'h40

// invtlb ops above this decode as illegal
`define INVTLB_OP_MAX 6

`endif

/* rtl/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire                            in_valid,
  input  wire decode_pkg::fetch_bundle_t in_bundle,
  input  wire decode_pkg::cnt_t          counter,
  input  wire                            kill,
  output logic                           out_valid,
  output decode_pkg::decoded_bundle_t    out_bundle
);

  import decode_pkg::*;

  logic            fetch_valid;
  fetch_bundle_t   fetch_q;
  decoded_bundle_t dec;

  decoder i_decoder (
    .fetch   (fetch_q),
    .counter (counter),
    .dec     (dec)
  );

  // kill drops both the bundle in the fetch register and the one arriving
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fetch_valid <= 1'b0;
      out_valid   <= 1'b0;
    end else if (kill) begin
      fetch_valid <= 1'b0;
      out_valid   <= 1'b0;
    end else begin
      fetch_valid <= in_valid;
      out_valid   <= fetch_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      fetch_q <= in_bundle;
    end
    if (fetch_valid) begin
      out_bundle <= dec;
    end
  end

endmodule

`default_nettype wire

/* rtl/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "decode_settings.svh"

module decoder (
  input  wire decode_pkg::fetch_bundle_t fetch,
  input  wire decode_pkg::cnt_t          counter,
  output decode_pkg::decoded_bundle_t    dec
);

  import decode_pkg::*;

  localparam reg_idx_t R0 = 5'd0;
  localparam reg_idx_t R1 = 5'd1;

  typedef struct packed {
    logic     valid;
    optype_t  optype;
    opcode_t  opcode;
    reg_idx_t r1;
    reg_idx_t r2;
    logic     src2_is_imm;
    word_t    imm;
    reg_idx_t dest;
  } row_t;

  typedef struct packed {
    br_type_t kind;
    logic     cond;
    word_t    target;
  } br_row_t;

  row_t     base;
  br_row_t  br;
  br_type_t jirl_type;
  excp_t    excp;
  logic     valid_inst;
  logic     is_invtlb;
  logic     is_jirl;
  logic     br_taken;
  logic     br_mistaken;

  wire word_t    pc   = fetch.pc;
  wire word_t    inst = fetch.inst;
  wire reg_idx_t rd   = inst[4:0];
  wire reg_idx_t rj   = inst[9:5];
  wire reg_idx_t rk   = inst[14:10];

  wire word_t ui5  = {27'd0, inst[14:10]};
  wire word_t si12 = {{20{inst[21]}}, inst[21:10]};
  wire word_t ui12 = {20'd0, inst[21:10]};
  wire word_t si16 = {{14{inst[25]}}, inst[25:10], 2'b0};
  wire word_t si20 = {inst[24:5], 12'b0};
  wire word_t si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

  wire inst_rdcnt   = inst[31:10] == 22'b0000000000000000011000;
  wire inst_rdcntid = inst_rdcnt && rd == R0 && rj != R0;
  wire inst_rdcntvl = inst_rdcnt && rd != R0 && rj == R0;
  wire inst_syscall = inst[31:15] == 17'b00000000001010110;
  wire inst_break   = inst[31:15] == 17'b00000000001010100;
  wire inst_ertn    = inst == 32'b00000110010010000011100000000000;

  function automatic row_t mk_row(input optype_t ot, input opcode_t oc, input reg_idx_t a,
                                  input reg_idx_t b, input logic s2i, input word_t imm,
                                  input reg_idx_t d);
    return '{1'b1, ot, oc, a, b, s2i, imm, d};
  endfunction

  // base table, unmatched words leave valid clear
  always_comb begin
    base = '0;
    casez (inst)
      {17'b00000000000100000, 15'b?}: base = mk_row(OP_ALU, ALU_ADD, rj, rk, 1'b0, '0, rd);
      {17'b00000000000100010, 15'b?}: base = mk_row(OP_ALU, ALU_SUB, rj, rk, 1'b0, '0, rd);
      {17'b00000000000100100, 15'b?}: base = mk_row(OP_ALU, ALU_SLT, rj, rk, 1'b0, '0, rd);
      {17'b00000000000100101, 15'b?}: base = mk_row(OP_ALU, ALU_SLTU, rj, rk, 1'b0, '0, rd);
      {17'b00000000000101000, 15'b?}: base = mk_row(OP_ALU, ALU_NOR, rj, rk, 1'b0, '0, rd);
      {17'b00000000000101001, 15'b?}: base = mk_row(OP_ALU, ALU_AND, rj, rk, 1'b0, '0, rd);
      {17'b00000000000101010, 15'b?}: base = mk_row(OP_ALU, ALU_OR, rj, rk, 1'b0, '0, rd);
      {17'b00000000000101011, 15'b?}: base = mk_row(OP_ALU, ALU_XOR, rj, rk, 1'b0, '0, rd);
      {17'b00000000000101110, 15'b?}: base = mk_row(OP_ALU, ALU_SLL, rj, rk, 1'b0, '0, rd);
      {17'b00000000000101111, 15'b?}: base = mk_row(OP_ALU, ALU_SRL, rj, rk, 1'b0, '0, rd);
      {17'b00000000000110000, 15'b?}: base = mk_row(OP_ALU, ALU_SRA, rj, rk, 1'b0, '0, rd);
      {17'b00000000000111000, 15'b?}: base = mk_row(OP_MUL, MUL_MUL, rj, rk, 1'b0, '0, rd);
      {17'b00000000000111001, 15'b?}: base = mk_row(OP_MUL, MUL_MULH, rj, rk, 1'b0, '0, rd);
      {17'b00000000000111010, 15'b?}: base = mk_row(OP_MUL, MUL_MULHU, rj, rk, 1'b0, '0, rd);
      {17'b00000000001000000, 15'b?}: base = mk_row(OP_DIV, DIV_DIV, rj, rk, 1'b0, '0, rd);
      {17'b00000000001000001, 15'b?}: base = mk_row(OP_DIV, DIV_MOD, rj, rk, 1'b0, '0, rd);
      {17'b00000000001000010, 15'b?}: base = mk_row(OP_DIV, DIV_DIVU, rj, rk, 1'b0, '0, rd);
      {17'b00000000001000011, 15'b?}: base = mk_row(OP_DIV, DIV_MODU, rj, rk, 1'b0, '0, rd);
      {17'b00000000010000001, 15'b?}: base = mk_row(OP_ALU, ALU_SLL, rj, R0, 1'b1, ui5, rd);
      {17'b00000000010001001, 15'b?}: base = mk_row(OP_ALU, ALU_SRL, rj, R0, 1'b1, ui5, rd);
      {17'b00000000010010001, 15'b?}: base = mk_row(OP_ALU, ALU_SRA, rj, R0, 1'b1, ui5, rd);
      {10'b0000001000, 22'b?}: base = mk_row(OP_ALU, ALU_SLT, rj, R0, 1'b1, si12, rd);
      {10'b0000001001, 22'b?}: base = mk_row(OP_ALU, ALU_SLTU, rj, R0, 1'b1, si12, rd);
      {10'b0000001010, 22'b?}: base = mk_row(OP_ALU, ALU_ADD, rj, R0, 1'b1, si12, rd);
      {10'b0000001101, 22'b?}: base = mk_row(OP_ALU, ALU_AND, rj, R0, 1'b1, ui12, rd);
      {10'b0000001110, 22'b?}: base = mk_row(OP_ALU, ALU_OR, rj, R0, 1'b1, ui12, rd);
      {10'b0000001111, 22'b?}: base = mk_row(OP_ALU, ALU_XOR, rj, R0, 1'b1, ui12, rd);
      {7'b0001010, 25'b?}: base = mk_row(OP_ALU, ALU_OUT2, R0, R0, 1'b1, si20, rd);
      {7'b0001110, 25'b?}: base = mk_row(OP_ALU, ALU_OUT2, R0, R0, 1'b1, pc + si20, rd);
      // loads and stores carry the offset in imm, src2 stays a register
      {10'b0010100000, 22'b?}: base = mk_row(OP_MEM, {MEM_LOAD_S, MEM_BYTE}, rj, R0, 1'b0, si12, rd);
      {10'b0010100001, 22'b?}: base = mk_row(OP_MEM, {MEM_LOAD_S, MEM_HALF}, rj, R0, 1'b0, si12, rd);
      {10'b0010100010, 22'b?}: base = mk_row(OP_MEM, {MEM_LOAD_S, MEM_WORD}, rj, R0, 1'b0, si12, rd);
      {10'b0010101000, 22'b?}: base = mk_row(OP_MEM, {MEM_LOAD_U, MEM_BYTE}, rj, R0, 1'b0, si12, rd);
      {10'b0010101001, 22'b?}: base = mk_row(OP_MEM, {MEM_LOAD_U, MEM_HALF}, rj, R0, 1'b0, si12, rd);
      {10'b0010100100, 22'b?}: base = mk_row(OP_MEM, {MEM_STORE, MEM_BYTE}, rj, rd, 1'b0, si12, R0);
      {10'b0010100101, 22'b?}: base = mk_row(OP_MEM, {MEM_STORE, MEM_HALF}, rj, rd, 1'b0, si12, R0);
      {10'b0010100110, 22'b?}: base = mk_row(OP_MEM, {MEM_STORE, MEM_WORD}, rj, rd, 1'b0, si12, R0);
      // branches compare rj against rd
      {6'b010110, 26'b?}: base = mk_row(OP_ALU, ALU_EQU, rj, rd, 1'b0, '0, R0);
      {6'b010111, 26'b?}: base = mk_row(OP_ALU, ALU_EQU, rj, rd, 1'b0, '0, R0);
      {6'b011000, 26'b?}: base = mk_row(OP_ALU, ALU_SLT, rj, rd, 1'b0, '0, R0);
      {6'b011001, 26'b?}: base = mk_row(OP_ALU, ALU_SLT, rj, rd, 1'b0, '0, R0);
      {6'b011010, 26'b?}: base = mk_row(OP_ALU, ALU_SLTU, rj, rd, 1'b0, '0, R0);
      {6'b011011, 26'b?}: base = mk_row(OP_ALU, ALU_SLTU, rj, rd, 1'b0, '0, R0);
      {6'b010100, 26'b?}: base = mk_row(OP_ALU, ALU_OUT2, R0, R0, 1'b0, '0, R0);
      {6'b010101, 26'b?}: base = mk_row(OP_ALU, ALU_OUT2, R0, R0, 1'b1, pc + 32'd4, R1);
      {6'b010011, 26'b?}: base = mk_row(OP_ALU, ALU_OUT2, rj, R0, 1'b1, pc + 32'd4, rd);
      {22'b0000000000000000011000, 10'b?}: begin
        if (inst_rdcntid)
          base = mk_row(OP_CSR, 4'd0, R0, R0, 1'b0, '0, rj);
        else if (inst_rdcntvl)
          base = mk_row(OP_ALU, ALU_OUT2, R0, R0, 1'b1, counter[`INST_W-1:0], rd);
      end
      {22'b0000000000000000011001, 10'b?}:
        base = mk_row(OP_ALU, ALU_OUT2, R0, R0, 1'b1, counter[`CNT_W-1:`INST_W], rd);
      {8'b00000100, 24'b?}: base = mk_row(OP_CSR, 4'd0, rj, rd, 1'b0, '0, rd);
      {22'b0000011001001000001010, 10'b?}: base = mk_row(OP_TLB, TLB_TLBSRCH, R0, R0, 1'b0, '0, R0);
      {22'b0000011001001000001011, 10'b?}: base = mk_row(OP_TLB, TLB_TLBRD, R0, R0, 1'b0, '0, R0);
      {22'b0000011001001000001100, 10'b?}: base = mk_row(OP_TLB, TLB_TLBWR, R0, R0, 1'b0, '0, R0);
      {22'b0000011001001000001101, 10'b?}: base = mk_row(OP_TLB, TLB_TLBFILL, R0, R0, 1'b0, '0, R0);
      // invtlb op rides in imm
      {17'b00000110010010011, 15'b?}: base = mk_row(OP_TLB, TLB_INVTLB, rj, rk, 1'b0, {27'd0, rd}, R0);
      default: base = '0;
    endcase
  end

  assign jirl_type = (rd == R0 && rj == R1 && inst[25:10] == 16'd0) ? BR_RET : BR_INDIR;

  // branch table, jirl target is only the offset
  always_comb begin
    case (inst[31:26])
      6'b010110: br = '{BR_COND, 1'b1, pc + si16};
      6'b010111: br = '{BR_COND, 1'b0, pc + si16};
      6'b011000: br = '{BR_COND, 1'b1, pc + si16};
      6'b011001: br = '{BR_COND, 1'b0, pc + si16};
      6'b011010: br = '{BR_COND, 1'b1, pc + si16};
      6'b011011: br = '{BR_COND, 1'b0, pc + si16};
      6'b010100: br = '{BR_IMM, 1'b0, pc + si26};
      6'b010101: br = '{BR_CALL, 1'b0, pc + si26};
      6'b010011: br = '{jirl_type, 1'b0, si16};
      default:   br = '{BR_NOP, 1'b0, '0};
    endcase
  end

  assign is_jirl     = br.kind == BR_INDIR || br.kind == BR_RET;
  assign br_taken    = br.kind == BR_IMM || br.kind == BR_CALL;
  assign br_mistaken = fetch.pred_taken &&
                       (br.kind == BR_NOP || (!is_jirl && fetch.pred_target != br.target)) ||
                       !fetch.pred_taken && br_taken;

  assign valid_inst = base.valid || inst_syscall || inst_break || inst_ertn;
  assign is_invtlb  = base.optype == OP_TLB && base.opcode == TLB_INVTLB;

  // ertn first, illegal last
  always_comb begin
    excp = EXCP_NONE;
    if (inst_ertn)
      excp = EXCP_ERTN;
    else if (inst_syscall)
      excp = EXCP_SYS;
    else if (inst_break)
      excp = EXCP_BRK;
    else if (!valid_inst || (is_invtlb && rd > reg_idx_t'(`INVTLB_OP_MAX)))
      excp = EXCP_INE;
  end

  always_comb begin
    dec.pc           = pc;
    dec.optype       = base.optype;
    dec.opcode       = base.opcode;
    dec.r1           = base.r1;
    dec.r2           = base.r2;
    dec.dest         = base.dest;
    dec.src2_is_imm  = base.src2_is_imm;
    dec.imm          = base.imm;
    dec.br_type      = br.kind;
    dec.br_condition = br.cond;
    dec.br_target    = br.target;
    dec.br_taken     = br_taken;
    dec.br_mistaken  = br_mistaken;
    dec.have_excp    = excp != EXCP_NONE;
    dec.excp_type    = excp;
    dec.csr_addr     = inst_rdcntid ? csr_addr_t'(`CSR_TID_ADDR) : inst[23:10];
    dec.csr_wr       = rj == R1;
  end

endmodule

`default_nettype wire

/* rtl/redirect_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module redirect_unit (
  input  wire                              out_valid,
  input  wire decode_pkg::decoded_bundle_t out_bundle,
  output decode_pkg::redirect_t            redirect,
  output logic                             kill
);

  import decode_pkg::*;

  logic  mispredict;
  word_t seq_pc;

  assign mispredict = out_valid && out_bundle.br_mistaken;
  assign seq_pc     = out_bundle.pc + word_t'(4);

  // taken branches resume at their target, everything else falls through
  always_comb begin
    redirect.valid  = mispredict;
    redirect.target = out_bundle.br_taken ? out_bundle.br_target : seq_pc;
  end

  assign kill = mispredict;

endmodule

`default_nettype wire

/* rtl/stable_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module stable_counter (
  input  wire              clk,
  input  wire              arst_n,
  output decode_pkg::cnt_t counter
);

  // time source for rdcnt.vl.w / rdcnt.vh.w
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      counter <= '0;
    end else begin
      counter <= counter + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* test/decode_frontend_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_frontend_chk (
  input wire                        clk,
  input wire                        arst_n,
  input wire                        in_valid,
  input wire                        out_valid,
  input wire decode_pkg::redirect_t redirect,
  input wire                        kill
);

  int fails = 0;

  // nothing leaves the pipeline while reset is held
  reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid && !redirect.valid)
    else begin
      fails++;
      $error("output or redirect active during reset");
    end

  // two register stages between input strobe and output
  out_latency: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> $past(in_valid, 2))
    else begin
      fails++;
      $error("out_valid without an input two edges earlier");
    end

  out_follows: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && !kill ##1 !kill |=> out_valid)
    else begin
      fails++;
      $error("accepted input did not reach the output");
    end

  redirect_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    redirect.valid |=> !redirect.valid && !out_valid)
    else begin
      fails++;
      $error("redirect longer than one cycle or output right after it");
    end

endmodule

bind decode_frontend_top decode_frontend_chk i_chk (
  .clk       (clk),
  .arst_n    (arst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .redirect  (redirect),
  .kill      (kill)
);

`default_nettype wire

/* test/decode_frontend_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_frontend_tb;

  import decode_pkg::*;

  localparam int N_BUNDLES  = 74;
  localparam int MAX_CYCLES = 40 * N_BUNDLES + 100;

  // which field groups a bundle is compared on
  localparam logic [3:0] M_OPS = 4'b0001;
  localparam logic [3:0] M_BR  = 4'b0010;
  localparam logic [3:0] M_CSR = 4'b0100;
  localparam logic [3:0] M_CNT = 4'b1000;

  typedef struct packed {
    decoded_bundle_t b;
    word_t           redir;
    logic [3:0]      mask;
  } exp_t;

  logic            clk;
  logic            arst_n;
  logic            in_valid;
  fetch_bundle_t   in_bundle;
  logic            out_valid;
  decoded_bundle_t out_bundle;
  redirect_t       redirect;

  exp_t  exp_q[$];
  word_t pc;
  word_t last_cnt;
  int    errors = 0;
  int    cycles = 0;

  decode_frontend_top i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_bundle  (in_bundle),
    .out_valid  (out_valid),
    .out_bundle (out_bundle),
    .redirect   (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic decoded_bundle_t blank();
    decoded_bundle_t e;
    e = '0;
    e.pc = pc;
    return e;
  endfunction

  function automatic decoded_bundle_t ops_exp(input optype_t ot, input opcode_t oc,
                                              input reg_idx_t r1, input reg_idx_t r2,
                                              input reg_idx_t dest, input logic s2i,
                                              input word_t imm);
    decoded_bundle_t e;
    e = blank();
    e.optype = ot;
    e.opcode = oc;
    e.r1 = r1;
    e.r2 = r2;
    e.dest = dest;
    e.src2_is_imm = s2i;
    e.imm = imm;
    return e;
  endfunction

  function automatic decoded_bundle_t with_br(input decoded_bundle_t e, input br_type_t kind,
                                              input logic cond, input word_t tgt);
    decoded_bundle_t r;
    r = e;
    r.br_type = kind;
    r.br_condition = cond;
    r.br_target = tgt;
    r.br_taken = kind == BR_IMM || kind == BR_CALL;
    return r;
  endfunction

  function automatic decoded_bundle_t excp_exp(input excp_t x);
    decoded_bundle_t e;
    e = blank();
    e.excp_type = x;
    return e;
  endfunction

  // drives one bundle and queues its expectation unless it gets killed
  task automatic send(input word_t inst, input logic pt, input word_t ptgt,
                      input decoded_bundle_t e, input logic [3:0] mask, input bit keep);
    exp_t x;
    logic jirl;
    jirl = e.br_type == BR_INDIR || e.br_type == BR_RET;
    x.b = e;
    x.b.br_mistaken = (pt && (e.br_type == BR_NOP || (!jirl && ptgt != e.br_target)))
                      || (!pt && e.br_taken);
    x.b.have_excp = e.excp_type != EXCP_NONE;
    x.redir = e.br_taken ? e.br_target : e.pc + 32'd4;
    x.mask = mask;
    @(negedge clk);
    in_valid <= 1'b1;
    in_bundle <= '{pc, inst, pt, ptgt};
    if (keep)
      exp_q.push_back(x);
    pc = pc + 32'd4;
  endtask

  task automatic ops(input word_t inst, input optype_t ot, input opcode_t oc,
                     input reg_idx_t r1, input reg_idx_t r2, input reg_idx_t dest,
                     input logic s2i, input word_t imm, input logic [3:0] mask);
    send(inst, 1'b0, '0, ops_exp(ot, oc, r1, r2, dest, s2i, imm), mask, 1'b1);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      in_valid <= 1'b0;
    end
  endtask

  // the two bundles behind a mispredicted one
  task automatic drop_two();
    repeat (2) send({17'h00020, 15'h0421}, 1'b0, '0, blank(), 4'd0, 1'b0);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("MISMATCH %s got %h expected %h", name, got, want);
    end
  endtask

  task automatic compare(input exp_t x);
    decoded_bundle_t e;
    e = x.b;
    check("pc", out_bundle.pc, e.pc);
    check("br_type", out_bundle.br_type, e.br_type);
    check("br_mistaken", out_bundle.br_mistaken, e.br_mistaken);
    check("have_excp", out_bundle.have_excp, e.have_excp);
    check("excp_type", out_bundle.excp_type, e.excp_type);
    check("redirect.valid", redirect.valid, e.br_mistaken);
    if (e.br_mistaken)
      check("redirect.target", redirect.target, x.redir);
    if ((x.mask & (M_OPS | M_CNT)) != 0) begin
      check("optype", out_bundle.optype, e.optype);
      check("opcode", out_bundle.opcode, e.opcode);
      check("r1", out_bundle.r1, e.r1);
      check("r2", out_bundle.r2, e.r2);
      check("dest", out_bundle.dest, e.dest);
      check("src2_is_imm", out_bundle.src2_is_imm, e.src2_is_imm);
      if ((x.mask & M_CNT) != 0) begin
        assert (out_bundle.imm > last_cnt) else begin
          errors++;
          $display("counter read %h is not above the previous read %h", out_bundle.imm,
                   last_cnt);
        end
        last_cnt = out_bundle.imm;
      end else begin
        check("imm", out_bundle.imm, e.imm);
      end
    end
    if ((x.mask & M_BR) != 0) begin
      check("br_condition", out_bundle.br_condition, e.br_condition);
      check("br_target", out_bundle.br_target, e.br_target);
      check("br_taken", out_bundle.br_taken, e.br_taken);
    end
    if ((x.mask & M_CSR) != 0) begin
      check("optype", out_bundle.optype, e.optype);
      check("dest", out_bundle.dest, e.dest);
      check("csr_addr", out_bundle.csr_addr, e.csr_addr);
      check("csr_wr", out_bundle.csr_wr, e.csr_wr);
    end
  endtask

  task automatic print_counts();
    $display("errors: %0d in testbench checks, %0d in assertions", errors, i_dut.i_chk.fails);
  endtask

  // output bundles against the expected queue
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("output bundle with pc %h arrived when none was expected", out_bundle.pc);
      end
      if (exp_q.size() != 0)
        compare(exp_q.pop_front());
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d bundles still expected", cycles, exp_q.size());
    print_counts();
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    logic [31:0] w;
    logic [31:0] v;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    logic [11:0] i12;
    word_t sx12;
    word_t zx12;
    word_t hi;
    word_t off16;
    word_t off26;
    decoded_bundle_t e;
    w = $urandom(59);
    pc = 32'h1c00_0000;
    last_cnt = '0;
    in_valid = 1'b0;
    in_bundle = '0;
    arst_n = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    idle(2);
    // high counter word is still zero this early
    ops({22'h000019, 5'd0, 5'd5}, OP_ALU, ALU_OUT2, 5'd0, 5'd0, 5'd5, 1'b1, '0, M_OPS);

    repeat (2) begin
      w = $urandom();
      v = $urandom();
      rd = w[4:0];
      rj = w[9:5];
      rk = w[14:10];
      i12 = w[26:15];
      sx12 = {{20{i12[11]}}, i12};
      zx12 = {20'd0, i12};
      hi = {v[19:0], 12'h000};
      ops({17'h00020, rk, rj, rd}, OP_ALU, ALU_ADD, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00022, rk, rj, rd}, OP_ALU, ALU_SUB, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00025, rk, rj, rd}, OP_ALU, ALU_SLTU, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00028, rk, rj, rd}, OP_ALU, ALU_NOR, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h0002b, rk, rj, rd}, OP_ALU, ALU_XOR, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00030, rk, rj, rd}, OP_ALU, ALU_SRA, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00038, rk, rj, rd}, OP_MUL, MUL_MUL, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h0003a, rk, rj, rd}, OP_MUL, MUL_MULHU, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00040, rk, rj, rd}, OP_DIV, DIV_DIV, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00043, rk, rj, rd}, OP_DIV, DIV_MODU, rj, rk, rd, 1'b0, '0, M_OPS);
      ops({17'h00081, rk, rj, rd}, OP_ALU, ALU_SLL, rj, 5'd0, rd, 1'b1, {27'd0, rk}, M_OPS);
      ops({17'h00091, rk, rj, rd}, OP_ALU, ALU_SRA, rj, 5'd0, rd, 1'b1, {27'd0, rk}, M_OPS);
      ops({10'h00a, i12, rj, rd}, OP_ALU, ALU_ADD, rj, 5'd0, rd, 1'b1, sx12, M_OPS);
      ops({10'h009, i12, rj, rd}, OP_ALU, ALU_SLTU, rj, 5'd0, rd, 1'b1, sx12, M_OPS);
      ops({10'h00d, i12, rj, rd}, OP_ALU, ALU_AND, rj, 5'd0, rd, 1'b1, zx12, M_OPS);
      ops({10'h00f, i12, rj, rd}, OP_ALU, ALU_XOR, rj, 5'd0, rd, 1'b1, zx12, M_OPS);
      ops({7'h0a, v[19:0], rd}, OP_ALU, ALU_OUT2, 5'd0, 5'd0, rd, 1'b1, hi, M_OPS);
      ops({7'h0e, v[19:0], rd}, OP_ALU, ALU_OUT2, 5'd0, 5'd0, rd, 1'b1, pc + hi, M_OPS);
      ops({10'h0a2, i12, rj, rd}, OP_MEM, {MEM_LOAD_S, MEM_WORD}, rj, 5'd0, rd, 1'b0, sx12, M_OPS);
      ops({10'h0a1, i12, rj, rd}, OP_MEM, {MEM_LOAD_S, MEM_HALF}, rj, 5'd0, rd, 1'b0, sx12, M_OPS);
      ops({10'h0a8, i12, rj, rd}, OP_MEM, {MEM_LOAD_U, MEM_BYTE}, rj, 5'd0, rd, 1'b0, sx12, M_OPS);
      ops({10'h0a4, i12, rj, rd}, OP_MEM, {MEM_STORE, MEM_BYTE}, rj, rd, 5'd0, 1'b0, sx12, M_OPS);
      ops({10'h0a6, i12, rj, rd}, OP_MEM, {MEM_STORE, MEM_WORD}, rj, rd, 5'd0, 1'b0, sx12, M_OPS);
    end

    // branches with correct predictions
    w = $urandom();
    off16 = {{14{w[15]}}, w[15:0], 2'b00};
    off26 = {{4{w[25]}}, w[25:16], w[15:0], 2'b00};
    send({6'h16, w[15:0], rj, rd}, 1'b1, pc + off16,
         with_br(blank(), BR_COND, 1'b1, pc + off16), M_BR, 1'b1);
    send({6'h17, w[15:0], rj, rd}, 1'b0, '0,
         with_br(blank(), BR_COND, 1'b0, pc + off16), M_BR, 1'b1);
    send({6'h1a, w[15:0], rj, rd}, 1'b0, '0,
         with_br(blank(), BR_COND, 1'b1, pc + off16), M_BR, 1'b1);
    send({6'h14, w[15:0], w[25:16]}, 1'b1, pc + off26,
         with_br(blank(), BR_IMM, 1'b0, pc + off26), M_BR, 1'b1);
    e = ops_exp(OP_ALU, ALU_OUT2, 5'd0, 5'd0, 5'd1, 1'b1, pc + 32'd4);
    send({6'h15, w[15:0], w[25:16]}, 1'b1, pc + off26,
         with_br(e, BR_CALL, 1'b0, pc + off26), M_BR | M_OPS, 1'b1);
    e = ops_exp(OP_ALU, ALU_OUT2, rj, 5'd0, 5'd3, 1'b1, pc + 32'd4);
    send({6'h13, w[15:0], rj, 5'd3}, 1'b1, pc + 32'd8,
         with_br(e, BR_INDIR, 1'b0, off16), M_BR | M_OPS, 1'b1);
    e = ops_exp(OP_ALU, ALU_OUT2, 5'd1, 5'd0, 5'd0, 1'b1, pc + 32'd4);
    send({6'h13, 16'h0000, 5'd1, 5'd0}, 1'b1, 32'h0000_1234,
         with_br(e, BR_RET, 1'b0, '0), M_BR | M_OPS, 1'b1);

    // mispredictions each followed by two bundles that must vanish
    send({17'h00020, rk, rj, rd}, 1'b1, pc + 32'h40,
         ops_exp(OP_ALU, ALU_ADD, rj, rk, rd, 1'b0, '0), M_OPS, 1'b1);
    drop_two();
    send({6'h16, w[15:0], rj, rd}, 1'b1, pc + off16 + 32'd8,
         with_br(blank(), BR_COND, 1'b1, pc + off16), M_BR, 1'b1);
    drop_two();
    send({6'h14, w[15:0], w[25:16]}, 1'b0, '0,
         with_br(blank(), BR_IMM, 1'b0, pc + off26), M_BR, 1'b1);
    drop_two();

    // exceptions
    send({17'h00056, w[14:0]}, 1'b0, '0, excp_exp(EXCP_SYS), 4'd0, 1'b1);
    send({17'h00054, w[14:0]}, 1'b0, '0, excp_exp(EXCP_BRK), 4'd0, 1'b1);
    send(32'h0648_3800, 1'b0, '0, excp_exp(EXCP_ERTN), 4'd0, 1'b1);
    send(32'h0000_0000, 1'b0, '0, excp_exp(EXCP_INE), 4'd0, 1'b1);
    send({17'h00c93, rk, rj, 5'd7}, 1'b0, '0, excp_exp(EXCP_INE), 4'd0, 1'b1);
    send({17'h00c93, rk, rj, 5'd6}, 1'b0, '0, excp_exp(EXCP_NONE), 4'd0, 1'b1);

    // csr access and counter id
    e = ops_exp(OP_CSR, 4'd0, 5'd1, rd, rd, 1'b0, '0);
    e.csr_addr = w[13:0];
    e.csr_wr = 1'b1;
    send({8'h04, w[13:0], 5'd1, rd}, 1'b0, '0, e, M_CSR, 1'b1);
    e = ops_exp(OP_CSR, 4'd0, 5'd0, rd, rd, 1'b0, '0);
    e.csr_addr = w[27:14];
    send({8'h04, w[27:14], 5'd0, rd}, 1'b0, '0, e, M_CSR, 1'b1);
    e = ops_exp(OP_CSR, 4'd0, 5'd0, 5'd0, 5'd7, 1'b0, '0);
    e.csr_addr = 14'h0040;
    send({22'h000018, 5'd7, 5'd0}, 1'b0, '0, e, M_CSR, 1'b1);

    // low counter word read twice with a gap
    ops({22'h000018, 5'd0, 5'd6}, OP_ALU, ALU_OUT2, 5'd0, 5'd0, 5'd6, 1'b1, '0, M_CNT);
    idle(6);
    ops({22'h000018, 5'd0, 5'd9}, OP_ALU, ALU_OUT2, 5'd0, 5'd0, 5'd9, 1'b1, '0, M_CNT);

    idle(1);
    while (exp_q.size() != 0)
      @(negedge clk);
    idle(4);
    print_counts();
    if (errors == 0 && i_dut.i_chk.fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
